//--- Bender.yml
package:
  name: axil_ram

sources:
  # Packages first, then the RTL from the leaves up
  - hdl/ram_cfg_pkg.sv
  - hdl/ram_bus_pkg.sv
  - hdl/ram_delay_valid.sv
  - hdl/ram_flops_1r1w.sv
  - hdl/axil_ram_front.sv
  - hdl/axil_ram_top.sv

  # Testbench, top module axil_ram_tb
  - target: test
    include_dirs:
      - test
    files:
      - test/axil_ram_tb.sv

//--- hdl/axil_ram_front.sv
// AXI4-Lite front end for the scratch RAM
`timescale 1ns/1ps
`default_nettype none

module axil_ram_front (
  input  logic                      wr_clk,
  input  logic                      wr_rst,
  // AW
  input  logic                      awvalid,
  output logic                      awready,
  input  ram_bus_pkg::axil_addr_t   awaddr,
  // W
  input  logic                      wvalid,
  output logic                      wready,
  input  ram_bus_pkg::axil_w_t      w,
  // B
  output logic                      bvalid,
  input  logic                      bready,
  output ram_bus_pkg::axil_resp_t   bresp,
  // AR
  input  logic                      arvalid,
  output logic                      arready,
  input  ram_bus_pkg::axil_addr_t   araddr,
  // R
  output logic                      rvalid,
  input  logic                      rready,
  output ram_bus_pkg::axil_r_t      r,
  // Memory side
  output logic                      wr_valid,
  output ram_cfg_pkg::ram_wr_cmd_t  wr_cmd,
  output logic                      rd_addr_valid,
  output ram_cfg_pkg::ram_index_t   rd_addr,
  input  logic                      rd_data_valid,
  input  ram_cfg_pkg::ram_rd_data_t rd_data
);

  import ram_cfg_pkg::*;
  import ram_bus_pkg::*;

  localparam int PTR_W = $clog2(RD_CREDITS);
  localparam int CNT_W = PTR_W + 1;

  // Low during reset and the cycle after
  logic ready_en_q;

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Write path
  // ----------------------------------------------------------

  logic       b_valid_q;
  axil_resp_t b_resp_q;
  logic       b_free;
  logic       wr_accept;
  logic       wr_in_range;

  // B slot free now or emptied this cycle
  assign b_free = !b_valid_q || bready;

  // AW and W taken together only
  assign awready   = ready_en_q && b_free && wvalid;
  assign wready    = ready_en_q && b_free && awvalid;
  assign wr_accept = awvalid && awready;

  assign wr_in_range = awaddr < RAM_BYTES;

  // Byte address to entry index, strobes to lane enables
  assign wr_valid       = wr_accept && wr_in_range;
  assign wr_cmd.index   = awaddr[BYTE_OFF_WIDTH +: INDEX_WIDTH];
  assign wr_cmd.data    = w.data;
  assign wr_cmd.word_en = w.strb;

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      b_valid_q <= 1'b0;
    end else if (wr_accept) begin
      b_valid_q <= 1'b1;
    end else if (bready) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign bvalid = b_valid_q;
  assign bresp  = b_resp_q;

  // ----------------------------------------------------------
  // Read requests and credits
  // ----------------------------------------------------------

  logic [CNT_W-1:0] credit_cnt;
  logic             ar_accept;
  logic             r_accept;
  logic             rd_in_range;

  assign arready     = ready_en_q && (credit_cnt < RD_CREDITS);
  assign ar_accept   = arvalid && arready;
  assign r_accept    = rvalid && rready;
  assign rd_in_range = araddr < RAM_BYTES;

  // Only in-range reads reach the memory
  assign rd_addr_valid = ar_accept && rd_in_range;
  assign rd_addr       = araddr[BYTE_OFF_WIDTH +: INDEX_WIDTH];

  // Taken on AR, returned on R
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_cnt + CNT_W'(ar_accept) - CNT_W'(r_accept);
    end
  end

  // ----------------------------------------------------------
  // In-order range flags
  // ----------------------------------------------------------

  logic [RD_CREDITS-1:0] flag_q;   // Bit 0 is the oldest read
  logic [CNT_W-1:0]      flag_cnt;
  logic [PTR_W-1:0]      flag_slot;
  logic                  fifo_push;
  axil_r_t               fifo_entry;

  // Memory data always belongs to the head, an out-of-range head drains at once
  assign fifo_push = rd_data_valid || ((flag_cnt != '0) && !flag_q[0]);
  assign flag_slot = PTR_W'(flag_cnt - CNT_W'(fifo_push));

  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      flag_cnt <= '0;
    end else begin
      flag_cnt <= flag_cnt + CNT_W'(ar_accept) - CNT_W'(fifo_push);
    end
  end

  // Shift out on pop, new flag lands behind the survivors
  always_ff @(posedge wr_clk) begin
    if (fifo_push) begin
      flag_q <= flag_q >> 1;
    end
    if (ar_accept) begin
      flag_q[flag_slot] <= rd_in_range;
    end
  end

  always_comb begin
    if (rd_data_valid) begin
      fifo_entry.data = rd_data;
      fifo_entry.resp = RESP_OKAY;
    end else begin
      fifo_entry.data = '0;
      fifo_entry.resp = RESP_SLVERR;
    end
  end

  // ----------------------------------------------------------
  // R response FIFO
  // ----------------------------------------------------------

  axil_r_t        r_mem [RD_CREDITS];
  logic [PTR_W:0] r_wr_ptr;
  logic [PTR_W:0] r_rd_ptr;

  // Credits keep the FIFO from overflowing
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      r_wr_ptr <= r_wr_ptr + (PTR_W + 1)'(fifo_push);
      r_rd_ptr <= r_rd_ptr + (PTR_W + 1)'(r_accept);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (fifo_push) begin
      r_mem[r_wr_ptr[PTR_W-1:0]] <= fifo_entry;
    end
  end

  assign rvalid = r_wr_ptr != r_rd_ptr;
  assign r      = r_mem[r_rd_ptr[PTR_W-1:0]];

endmodule : axil_ram_front

`default_nettype wire

//--- hdl/axil_ram_top.sv
// AXI4-Lite scratch RAM top
`timescale 1ns/1ps
`default_nettype none

module axil_ram_top (
  input  logic                    wr_clk,
  input  logic                    wr_rst,
  // Write address
  input  logic                    awvalid,
  output logic                    awready,
  input  ram_bus_pkg::axil_addr_t awaddr,
  // Write data
  input  logic                    wvalid,
  output logic                    wready,
  input  ram_bus_pkg::axil_w_t    w,
  // Write response
  output logic                    bvalid,
  input  logic                    bready,
  output ram_bus_pkg::axil_resp_t bresp,
  // Read address
  input  logic                    arvalid,
  output logic                    arready,
  input  ram_bus_pkg::axil_addr_t araddr,
  // Read data
  output logic                    rvalid,
  input  logic                    rready,
  output ram_bus_pkg::axil_r_t    r
);

  import ram_cfg_pkg::*;

  // Front end to memory, no back-pressure
  logic         wr_valid;
  ram_wr_cmd_t  wr_cmd;
  logic         rd_addr_valid;
  ram_index_t   rd_addr;
  logic         rd_data_valid;
  ram_rd_data_t rd_data;

  axil_ram_front u_front (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .awvalid       (awvalid),
    .awready       (awready),
    .awaddr        (awaddr),
    .wvalid        (wvalid),
    .wready        (wready),
    .w             (w),
    .bvalid        (bvalid),
    .bready        (bready),
    .bresp         (bresp),
    .arvalid       (arvalid),
    .arready       (arready),
    .araddr        (araddr),
    .rvalid        (rvalid),
    .rready        (rready),
    .r             (r),
    .wr_valid      (wr_valid),
    .wr_cmd        (wr_cmd),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  ram_flops_1r1w u_mem (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr_valid      (wr_valid),
    .wr_cmd        (wr_cmd),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

endmodule : axil_ram_top

`default_nettype wire

//--- hdl/ram_bus_pkg.sv
// AXI4-Lite bus types
`default_nettype none

package ram_bus_pkg;

  // ----------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------

  // Byte address width
  localparam int AXIL_ADDR_WIDTH = 32;
  // Data bus width
  localparam int AXIL_DATA_WIDTH = 32;
  // One strobe per data byte
  localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

  // Size of the decoded window in bytes
  // Anything at or above answers SLVERR
  localparam int RAM_BYTES = 256;

  // ----------------------------------------------------------
  // Field types
  // ----------------------------------------------------------

  typedef logic [AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [AXIL_STRB_WIDTH-1:0] axil_strb_t;

  // Response codes, EXOKAY and DECERR never produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------

  // W channel payload, 36 bits
  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

  // R channel payload, 34 bits
  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } axil_r_t;

endpackage : ram_bus_pkg

`default_nettype wire

//--- hdl/ram_cfg_pkg.sv
// Scratch RAM configuration
`default_nettype none

package ram_cfg_pkg;

  // ----------------------------------------------------------
  // Array geometry
  // ----------------------------------------------------------

  // Entries in the array
  localparam int RAM_DEPTH = 64;
  // Bits per entry
  localparam int DATA_WIDTH = 32;
  // Smallest writable unit, one byte lane
  localparam int WORD_WIDTH = 8;
  // Byte lanes per entry
  localparam int NUM_WORDS = DATA_WIDTH / WORD_WIDTH;
  // Entry index bits
  localparam int INDEX_WIDTH = $clog2(RAM_DEPTH);
  // Byte address bits below the entry index
  localparam int BYTE_OFF_WIDTH = $clog2(NUM_WORDS);

  // ----------------------------------------------------------
  // Pipeline and flow control
  // ----------------------------------------------------------

  // Stages on the write command and read address paths
  localparam int ADDR_STAGES = 1;
  // Stages on the read data path
  localparam int RD_DATA_STAGES = 1;
  // Cycles from read address to read data valid
  localparam int READ_LATENCY = ADDR_STAGES + RD_DATA_STAGES;
  // Reads in flight or buffered in the front end
  localparam int RD_CREDITS = 4;

  // ----------------------------------------------------------
  // Memory command types
  // ----------------------------------------------------------

  typedef logic [INDEX_WIDTH-1:0] ram_index_t;
  typedef logic [DATA_WIDTH-1:0] ram_rd_data_t;

  // Write command, 42 bits
  typedef struct packed {
    ram_index_t             index;
    ram_rd_data_t           data;
    logic [NUM_WORDS-1:0]   word_en;  // One enable per byte lane
  } ram_wr_cmd_t;

endpackage : ram_cfg_pkg

`default_nettype wire

//--- hdl/ram_delay_valid.sv
// Valid-qualified delay chain
`timescale 1ns/1ps
`default_nettype none

module ram_delay_valid #(
  parameter int Width     = 1,
  parameter int NumStages = 1
) (
  input  logic             wr_clk,
  input  logic             wr_rst,
  input  logic             in_valid,
  input  logic [Width-1:0] in,
  output logic             out_valid,
  output logic [Width-1:0] out
);

  if (NumStages == 0) begin : gen_pass
    // No stages, straight through
    assign out_valid = in_valid;
    assign out       = in;
  end else begin : gen_stages
    logic [NumStages-1:0]            valid_q;
    logic [NumStages-1:0][Width-1:0] data_q;

    // Valid shift register
    always_ff @(posedge wr_clk) begin
      if (wr_rst) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int i = 1; i < NumStages; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    // Payload moves only behind a set valid
    always_ff @(posedge wr_clk) begin
      if (in_valid) begin
        data_q[0] <= in;
      end
      for (int i = 1; i < NumStages; i++) begin
        if (valid_q[i-1]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    assign out_valid = valid_q[NumStages-1];
    assign out       = data_q[NumStages-1];
  end

endmodule : ram_delay_valid

`default_nettype wire

//--- hdl/ram_flops_1r1w.sv
// Flop RAM, one read and one write port
`timescale 1ns/1ps
`default_nettype none

module ram_flops_1r1w (
  input  logic                      wr_clk,
  input  logic                      wr_rst,
  // Write command
  input  logic                      wr_valid,
  input  ram_cfg_pkg::ram_wr_cmd_t  wr_cmd,
  // Read address
  input  logic                      rd_addr_valid,
  input  ram_cfg_pkg::ram_index_t   rd_addr,
  // Read data, READ_LATENCY after the address
  output logic                      rd_data_valid,
  output ram_cfg_pkg::ram_rd_data_t rd_data
);

  import ram_cfg_pkg::*;

  // Delayed write command
  logic        mem_wr_valid;
  ram_wr_cmd_t mem_wr_cmd;
  // Delayed read address
  logic        mem_rd_addr_valid;
  ram_index_t  mem_rd_addr;
  // Array side read data
  logic         mem_rd_data_valid;
  ram_rd_data_t mem_rd_data;
  // Same entry written and read in one cycle
  logic        bypass_hit;

  // Byte views
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] wr_bytes;
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] rd_bytes;

  // The array
  logic [NUM_WORDS-1:0][WORD_WIDTH-1:0] mem [RAM_DEPTH];

  // ----------------------------------------------------------
  // Address side stages
  // ----------------------------------------------------------

  ram_delay_valid #(
    .Width     ($bits(ram_wr_cmd_t)),
    .NumStages (ADDR_STAGES)
  ) u_wr_delay (
    .wr_clk    (wr_clk),
    .wr_rst    (wr_rst),
    .in_valid  (wr_valid),
    .in        (wr_cmd),
    .out_valid (mem_wr_valid),
    .out       (mem_wr_cmd)
  );

  ram_delay_valid #(
    .Width     (INDEX_WIDTH),
    .NumStages (ADDR_STAGES)
  ) u_rd_addr_delay (
    .wr_clk    (wr_clk),
    .wr_rst    (wr_rst),
    .in_valid  (rd_addr_valid),
    .in        (rd_addr),
    .out_valid (mem_rd_addr_valid),
    .out       (mem_rd_addr)
  );

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------

  assign wr_bytes = mem_wr_cmd.data;

  // Clear on reset, else byte-lane update
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      for (int e = 0; e < RAM_DEPTH; e++) begin
        mem[e] <= '0;
      end
    end else if (mem_wr_valid) begin
      for (int b = 0; b < NUM_WORDS; b++) begin
        if (mem_wr_cmd.word_en[b]) begin
          mem[mem_wr_cmd.index][b] <= wr_bytes[b];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read port with same-cycle bypass
  // ----------------------------------------------------------

  assign bypass_hit = mem_wr_valid && (mem_wr_cmd.index == mem_rd_addr);

  // Enabled lanes come from the write, the rest from the array
  always_comb begin
    for (int b = 0; b < NUM_WORDS; b++) begin
      if (bypass_hit && mem_wr_cmd.word_en[b]) begin
        rd_bytes[b] = wr_bytes[b];
      end else begin
        rd_bytes[b] = mem[mem_rd_addr][b];
      end
    end
  end

  assign mem_rd_data_valid = mem_rd_addr_valid;
  assign mem_rd_data       = rd_bytes;

  // Read data stages make up the rest of the latency
  ram_delay_valid #(
    .Width     (DATA_WIDTH),
    .NumStages (READ_LATENCY - ADDR_STAGES)
  ) u_rd_data_delay (
    .wr_clk    (wr_clk),
    .wr_rst    (wr_rst),
    .in_valid  (mem_rd_data_valid),
    .in        (mem_rd_data),
    .out_valid (rd_data_valid),
    .out       (rd_data)
  );

endmodule : ram_flops_1r1w

`default_nettype wire

//--- sources.f
+incdir+test
hdl/ram_cfg_pkg.sv
hdl/ram_bus_pkg.sv
hdl/ram_delay_valid.sv
hdl/ram_flops_1r1w.sv
hdl/axil_ram_front.sv
hdl/axil_ram_top.sv
test/axil_ram_tb.sv

//--- test/axil_ram_tb_tasks.svh
// Scratch RAM testbench tasks
`ifndef AXIL_RAM_TB_TASKS_SVH
`define AXIL_RAM_TB_TASKS_SVH

  // ----------------------------------------------------------
  // Run control and typed compares
  // ----------------------------------------------------------

  // Caller has already printed the reason
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_b(axil_resp_t got, axil_resp_t exp, string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %s, expected %s",
               $time, what, got.name(), exp.name());
      abort_run();
    end
  endtask

  task automatic check_r(axil_r_t got, axil_r_t exp, string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %h/%s, expected %h/%s",
               $time, what, got.data, got.resp.name(), exp.data, exp.resp.name());
      abort_run();
    end
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  // Byte-lane merge into the entry, SLVERR above the window
  function automatic axil_resp_t model_write(axil_addr_t addr, axil_data_t data,
                                             axil_strb_t strb);
    int idx;
    if (addr >= RAM_BYTES) begin
      return RESP_SLVERR;
    end
    idx = addr / 4;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    return RESP_OKAY;
  endfunction

  // Out of range reads give zero data
  function automatic axil_r_t model_read(axil_addr_t addr);
    axil_r_t res;
    if (addr >= RAM_BYTES) begin
      res.data = '0;
      res.resp = RESP_SLVERR;
    end else begin
      res.data = model_mem[addr / 4];
      res.resp = RESP_OKAY;
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Bus drivers
  // ----------------------------------------------------------

  // Every driver starts and ends 1 ns after a rising edge

  // AW and W offered together, DUT takes them in one cycle
  task automatic send_write(axil_addr_t addr, axil_data_t data, axil_strb_t strb);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    w.data  = data;
    w.strb  = strb;
    @(negedge wr_clk);
    while (!(awready && wready)) @(negedge wr_clk);
    @(posedge wr_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // bready stays high, so B leaves at the edge after sampling
  task automatic wait_b(output axil_resp_t resp);
    @(negedge wr_clk);
    while (!bvalid) @(negedge wr_clk);
    resp = bresp;
    @(posedge wr_clk);
    #1;
  endtask

  task automatic issue_read(axil_addr_t addr);
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge wr_clk);
    while (!arready) @(negedge wr_clk);
    @(posedge wr_clk);
    #1;
    arvalid = 1'b0;
  endtask

  // Hold rready low for a few cycles, then take the FIFO head
  task automatic collect_r(int hold, output axil_r_t got);
    if (hold > 0) begin
      rready = 1'b0;
      repeat (hold) begin
        @(posedge wr_clk);
        #1;
      end
    end
    rready = 1'b1;
    @(negedge wr_clk);
    while (!rvalid) @(negedge wr_clk);
    got = r;
    @(posedge wr_clk);
    #1;
  endtask

`endif

//--- test/axil_ram_tb.sv
// AXI4-Lite scratch RAM testbench
`timescale 1ns/1ps
`default_nettype none

module axil_ram_tb;

  import ram_cfg_pkg::*;
  import ram_bus_pkg::*;

  // ----------------------------------------------------------
  // Run constants and stimulus types
  // ----------------------------------------------------------

  localparam int TABLE_LEN      = 25;
  localparam int RANDOM_OPS     = 200;
  // Generous cycle budget per operation
  localparam int TIMEOUT_CYCLES = 40 * (TABLE_LEN + RANDOM_OPS);

  typedef enum logic [1:0] {
    OP_WR,     // Write and wait for B
    OP_RD,     // Read and wait for R after the rready hold
    OP_RDQ,    // Read with rready low and the response left pending
    OP_DRAIN   // Check the AR stall and then collect pending reads in order
  } op_t;

  typedef struct packed {
    op_t        op;
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    logic [3:0] hold;      // Cycles rready stays low
    axil_data_t exp_data;  // Filled from the model as the entry is built
    axil_resp_t exp_resp;
  } stim_t;

  // DUT ports
  logic       wr_clk;
  logic       wr_rst;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_w_t    w;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_r_t    r;

  stim_t      stim [TABLE_LEN];
  int         n_entries;
  axil_r_t    pend_q [$];            // Expected results of queued reads
  axil_data_t model_mem [RAM_BYTES/4];
  int         cycles;

  `include "axil_ram_tb_tasks.svh"

  axil_ram_top u_dut (
    .wr_clk  (wr_clk),
    .wr_rst  (wr_rst),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .w       (w),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r)
  );

  // 20 ns clock
  initial begin
    wr_clk = 1'b0;
    forever #10 wr_clk = ~wr_clk;
  end

  always @(posedge wr_clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: no finish after %0d clock cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------

  // Expected values come from the model in the order the entries run
  function automatic void fill_expected(inout stim_t s);
    axil_r_t exp_r;
    case (s.op)
      OP_WR: begin
        s.exp_data = '0;
        s.exp_resp = model_write(s.addr, s.data, s.strb);
      end
      OP_RD, OP_RDQ: begin
        exp_r      = model_read(s.addr);
        s.exp_data = exp_r.data;
        s.exp_resp = exp_r.resp;
      end
      default: begin
        s.exp_data = '0;
        s.exp_resp = RESP_OKAY;
      end
    endcase
  endfunction

  function automatic void add_entry(op_t op, axil_addr_t addr, axil_data_t data,
                                    axil_strb_t strb, logic [3:0] hold);
    stim_t e;
    e = '{op, addr, data, strb, hold, '0, RESP_OKAY};
    fill_expected(e);
    stim[n_entries] = e;
    n_entries++;
  endfunction

  function automatic void load_table();
    // Reset contents of every sixteenth entry
    add_entry(OP_RD, 32'h00, '0, '0, 0);
    add_entry(OP_RD, 32'h40, '0, '0, 0);
    add_entry(OP_RD, 32'h80, '0, '0, 1);
    add_entry(OP_RD, 32'hc0, '0, '0, 0);
    // Full strobe writes and read back
    add_entry(OP_WR, 32'h00, 32'hdeadbeef, 4'hf, 0);
    add_entry(OP_WR, 32'h04, 32'h12345678, 4'hf, 0);
    add_entry(OP_WR, 32'hfc, 32'ha5a55a5a, 4'hf, 0);
    add_entry(OP_RD, 32'h00, '0, '0, 0);
    add_entry(OP_RD, 32'h04, '0, '0, 2);
    add_entry(OP_RD, 32'hfc, '0, '0, 0);
    // Partial strobes touch only their lanes
    add_entry(OP_WR, 32'h04, 32'hffffffaa, 4'b0001, 0);
    add_entry(OP_WR, 32'h04, 32'h9988ffff, 4'b1100, 0);
    add_entry(OP_RD, 32'h04, '0, '0, 3);
    add_entry(OP_WR, 32'h08, 32'h00c3c300, 4'b0110, 0);
    add_entry(OP_RD, 32'h08, '0, '0, 0);
    // Outside the window the memory stays untouched
    add_entry(OP_WR, 32'h100, 32'h11111111, 4'hf, 0);
    add_entry(OP_RD, 32'h100, '0, '0, 0);
    add_entry(OP_WR, 32'h1000, 32'h22222222, 4'hf, 0);
    add_entry(OP_RD, 32'hfffffffc, '0, '0, 0);
    add_entry(OP_RD, 32'h00, '0, '0, 0);
    // Four reads behind a low rready with one of them out of range
    add_entry(OP_RDQ, 32'h00, '0, '0, 0);
    add_entry(OP_RDQ, 32'h04, '0, '0, 0);
    add_entry(OP_RDQ, 32'h104, '0, '0, 0);
    add_entry(OP_RDQ, 32'hfc, '0, '0, 0);
    add_entry(OP_DRAIN, '0, '0, '0, 0);
  endfunction

  // ----------------------------------------------------------
  // Apply one operation
  // ----------------------------------------------------------

  task automatic apply_op(input stim_t s);
    axil_resp_t got_b;
    axil_r_t    got_r;
    axil_r_t    exp_r;
    exp_r.data = s.exp_data;
    exp_r.resp = s.exp_resp;
    case (s.op)
      OP_WR: begin
        send_write(s.addr, s.data, s.strb);
        wait_b(got_b);
        check_b(got_b, s.exp_resp, $sformatf("write to %h", s.addr));
      end
      OP_RD: begin
        issue_read(s.addr);
        collect_r(s.hold, got_r);
        check_r(got_r, exp_r, $sformatf("read of %h", s.addr));
      end
      OP_RDQ: begin
        pend_q.push_back(exp_r);
        rready = 1'b0;
        issue_read(s.addr);
      end
      default: begin
        // AR must stall with all credits in use
        @(negedge wr_clk);
        if (pend_q.size() >= RD_CREDITS && arready) begin
          $display("Read address channel still ready with %0d reads pending",
                   pend_q.size());
          abort_run();
        end
        @(posedge wr_clk);
        #1;
        while (pend_q.size() > 0) begin
          exp_r = pend_q.pop_front();
          collect_r(0, got_r);
          check_r(got_r, exp_r, "queued read");
        end
      end
    endcase
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    stim_t s;
    void'($urandom(32'he63a8064));
    wr_rst  = 1'b1;
    // Requests offered during reset must not be taken
    awvalid = 1'b1;
    awaddr  = '0;
    wvalid  = 1'b1;
    w       = '0;
    bready  = 1'b1;
    arvalid = 1'b1;
    araddr  = '0;
    rready  = 1'b1;
    cycles  = 0;
    n_entries = 0;
    for (int i = 0; i < RAM_BYTES / 4; i++) begin
      model_mem[i] = '0;
    end
    load_table();

    // Ready and response valid outputs stay low through reset
    repeat (4) begin
      @(posedge wr_clk);
      #1;
      if (awready || wready || arready || bvalid || rvalid) begin
        $display("A handshake output was high while reset was asserted");
        abort_run();
      end
    end
    wr_rst  = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;

    for (int i = 0; i < n_entries; i++) begin
      apply_op(stim[i]);
    end

    // Random mix that is mostly in range
    for (int i = 0; i < RANDOM_OPS; i++) begin
      s      = '0;
      s.op   = ($urandom_range(0, 1) == 0) ? OP_WR : OP_RD;
      s.addr = $urandom_range(0, RAM_BYTES / 4 - 1) * 4;
      if ($urandom_range(0, 7) == 0) begin
        s.addr = RAM_BYTES + $urandom_range(0, 4095);
      end
      s.data = $urandom();
      s.strb = $urandom_range(0, 15);
      s.hold = $urandom_range(0, 3);
      fill_expected(s);
      apply_op(s);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule : axil_ram_tb

`default_nettype wire
